//--- all.f
+incdir+hw
hw/access_pkg.sv
hw/mem_pkg.sv
hw/access_arbiter.sv
hw/stride_addr_gen.sv
hw/local_memory.sv
hw/strided_access_top.sv
dv/clock_gen.sv
dv/access_checker.sv
dv/tb_strided_access.sv

//--- Makefile
# Verilator build and run of the strided access testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_strided_access
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_strided_access.sv
// Testbench top of the strided access unit
// Drives descriptors, store beats and lane credits, keeps a shadow memory
// and feeds expected words to the checker
`timescale 1ns/1ps
`include "stride_defs.svh"
`default_nettype none

module tb_strided_access;

	localparam int TOTAL_ELEMENTS = 118;									// Sum over all tests
	localparam int CYCLE_LIMIT = 40 * TOTAL_ELEMENTS + 200;

	logic						clock;
	logic						reset;
	logic [2:0]					req_valid;
	access_pkg::desc_t [2:0]	req_desc;
	logic [1:0]					lane_credit;
	mem_pkg::store_beat_t		store_in;
	mem_pkg::load_beat_t [1:0]	lane_beat;
	logic						store_credit;
	logic [2:0]					done;

	logic [`STRIDE_DATA_W-1:0]	shadow [256];								// Expected memory image
	int							pending [2];								// Words to credit back
	logic						withhold;									// Lane 0 back-pressure
	int							store_credits;
	int							credit_returns = 0;							// Store credit pulses
	int							tb_errors;
	int							cycles;
	int							passed;
	int							failed;
	int							done_log [$];								// Ports in done order

	clock_gen clock_gen_inst (
		.clock	(clock),
		.reset	(reset)
	);

	strided_access_top strided_access_top_inst (
		.clock			(clock),
		.reset			(reset),
		.req_valid		(req_valid),
		.req_desc		(req_desc),
		.lane_credit	(lane_credit),
		.store_in		(store_in),
		.lane_beat		(lane_beat),
		.store_credit	(store_credit),
		.done			(done)
	);

	access_checker access_checker_inst (
		.clock			(clock),
		.reset			(reset),
		.lane_beat		(lane_beat),
		.lane_credit	(lane_credit)
	);

	// Reference model of one strided element
	function automatic logic [31:0] expected_word(input int base, input int stride,
		input int index, input logic [31:0] mem [256]);
		return mem[(base + index * stride) % 256];
	endfunction

	function automatic access_pkg::desc_t make_desc(input int base, input int stride,
		input int length);
		access_pkg::desc_t d;
		d.base = 8'(base);
		d.stride = 8'(stride);
		d.length = 8'(length);
		return d;
	endfunction

	////////////////////////////////////////////////////////////
	// Credit return, done log and timeout
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		#1;
		for (int l = 0; l < 2; l++) begin
			if (!reset && lane_beat[l].valid) begin
				pending[l]++;												// Beat of this cycle
			end
			if (pending[l] > 0 && !(l == 0 && withhold && $urandom_range(0, 2) != 0)) begin
				lane_credit[l] = 1'b1;
				pending[l]--;
			end else begin
				lane_credit[l] = 1'b0;
			end
		end
	end

	always @(negedge clock) begin
		if (!reset) begin
			for (int p = 0; p < 3; p++) begin
				if (done[p]) begin
					done_log.push_back(p);
				end
			end
			if (store_credit) begin
				credit_returns++;
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles", cycles);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Access tasks
	////////////////////////////////////////////////////////////

	task automatic run_access(input int port, input access_pkg::desc_t d);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		req_desc[port] = d;
		req_valid[port] = 1'b1;
		while (!seen && n < 40 * int'(d.length) + 100) begin
			@(negedge clock);
			if (done[port]) seen = 1'b1;
			n++;
		end
		if (!seen) begin
			$display("Test %s: no done pulse for port %0d", access_checker_inst.test_name, port);
			tb_errors++;
		end
		@(posedge clock);
		#1 req_valid[port] = 1'b0;											// Cycle after done
	endtask

	task automatic send_stores(input access_pkg::desc_t d);
		logic [31:0] data;
		int addr;
		int n;
		for (int i = 0; i < int'(d.length); i++) begin
			data = $urandom;
			addr = (int'(d.base) + i * int'(d.stride)) % 256;
			while (store_credits == 0) begin
				@(posedge clock);
				#1;
			end
			store_credits--;
			store_in.valid = 1'b1;
			store_in.data = data;
			n = 0;
			do begin
				@(negedge clock);
				n++;
			end while (!store_credit && n < 2000);
			if (store_credit) begin
				shadow[addr] = data;										// Written at next edge
				store_credits++;
			end
			@(posedge clock);
			#1 store_in.valid = 1'b0;
		end
	endtask

	task automatic run_store(input access_pkg::desc_t d);
		fork
			run_access(2, d);
			send_stores(d);
		join
	endtask

	task automatic expect_load(input int lane, input access_pkg::desc_t d);
		for (int i = 0; i < int'(d.length); i++) begin
			access_checker_inst.push_expected(lane,
				expected_word(int'(d.base), int'(d.stride), i, shadow));
		end
	endtask

	task automatic end_test(input int errors_before, input int log_start, input int accesses);
		repeat (3) @(posedge clock);
		#1;
		for (int l = 0; l < 2; l++) begin
			if (access_checker_inst.leftover(l) != 0) begin
				$display("Test %s: %0d expected words never arrived on lane %0d",
					access_checker_inst.test_name, access_checker_inst.leftover(l), l);
				tb_errors++;
			end
		end
		if (done_log.size() - log_start != accesses) begin
			$display("Test %s: %0d done pulses where %0d accesses ran",
				access_checker_inst.test_name, done_log.size() - log_start, accesses);
			tb_errors++;
		end
		if (tb_errors + access_checker_inst.errors == errors_before) begin
			$display("Test %s: passed", access_checker_inst.test_name);
			passed++;
		end else begin
			$display("Test %s: failed", access_checker_inst.test_name);
			failed++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		access_pkg::desc_t d0;
		access_pkg::desc_t d1;
		access_pkg::desc_t d2;
		int base_err;
		int log_start;
		int credits_before;
		void'($urandom(56));
		req_valid = '0;
		req_desc = '0;
		lane_credit = '0;
		store_in = '0;
		withhold = 1'b0;
		store_credits = `STRIDE_CREDITS;
		pending[0] = 0;
		pending[1] = 0;
		tb_errors = 0;
		cycles = 0;
		passed = 0;
		failed = 0;
		wait (reset == 1'b0);
		@(posedge clock);
		#1;

		access_checker_inst.test_name = "store_load";
		base_err = 0;
		log_start = done_log.size();
		d0 = make_desc(10, 3, 16);
		run_store(d0);
		expect_load(0, d0);
		run_access(0, d0);
		end_test(base_err, log_start, 2);

		access_checker_inst.test_name = "wrap";
		base_err = tb_errors + access_checker_inst.errors;
		log_start = done_log.size();
		d1 = make_desc(250, 7, 10);
		run_store(d1);
		expect_load(1, d1);
		run_access(1, d1);
		end_test(base_err, log_start, 2);

		access_checker_inst.test_name = "priority";
		base_err = tb_errors + access_checker_inst.errors;
		log_start = done_log.size();
		d2 = make_desc(100, 1, 8);											// Disjoint from loads
		expect_load(0, d0);
		expect_load(1, d1);
		fork
			run_access(0, d0);
			run_access(1, d1);
			run_store(d2);
		join
		if (done_log.size() - log_start != 3 || done_log[log_start] != 0
			|| done_log[log_start + 1] != 1 || done_log[log_start + 2] != 2) begin
			$display("Test priority: done pulses out of order lane 0, lane 1, store");
			tb_errors++;
		end
		end_test(base_err, log_start, 3);

		access_checker_inst.test_name = "back_pressure";
		base_err = tb_errors + access_checker_inst.errors;
		log_start = done_log.size();
		withhold = 1'b1;
		expect_load(0, d0);
		run_access(0, d0);
		withhold = 1'b0;
		end_test(base_err, log_start, 1);

		access_checker_inst.test_name = "store_credit";
		base_err = tb_errors + access_checker_inst.errors;
		log_start = done_log.size();
		d2 = make_desc(200, 1, 6);
		credits_before = credit_returns;
		run_store(d2);
		if (credit_returns - credits_before != int'(d2.length)) begin
			$display("Fail store_credit: expected %0d, actual %0d", d2.length,
				credit_returns - credits_before);
			tb_errors++;
		end
		expect_load(1, d2);
		run_access(1, d2);
		end_test(base_err, log_start, 2);

		access_checker_inst.test_name = "zero_length";
		base_err = tb_errors + access_checker_inst.errors;
		log_start = done_log.size();
		run_access(2, make_desc(10, 3, 0));									// No beats sent
		d0 = make_desc(10, 3, 4);
		expect_load(0, d0);
		run_access(0, d0);
		end_test(base_err, log_start, 2);

		$display("Passed %0d, failed %0d, errors %0d", passed, failed,
			tb_errors + access_checker_inst.errors);
		if (failed == 0 && tb_errors + access_checker_inst.errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/access_checker.sv
// Monitor for the lane outputs of the strided access unit
// The testbench pushes expected words per lane, each lane beat is compared
// in order, and outstanding beats per lane are checked against the credit limit
`timescale 1ns/1ps
`include "stride_defs.svh"
`default_nettype none

module access_checker (
	input  wire logic							clock,
	input  wire logic							reset,
	input  wire mem_pkg::load_beat_t [1:0]		lane_beat,
	input  wire logic [1:0]						lane_credit
);

	logic [`STRIDE_DATA_W-1:0]	exp_q0 [$];									// Expected words lane 0
	logic [`STRIDE_DATA_W-1:0]	exp_q1 [$];									// Expected words lane 1
	int							outstanding [2];							// Beats without credit
	int							errors;
	string						test_name;

	initial begin
		errors = 0;
		outstanding[0] = 0;
		outstanding[1] = 0;
		test_name = "none";
	end

	task automatic push_expected(input int lane, input logic [`STRIDE_DATA_W-1:0] word);
		if (lane == 0) begin
			exp_q0.push_back(word);
		end else begin
			exp_q1.push_back(word);
		end
	endtask

	function automatic int leftover(input int lane);
		return (lane == 0) ? exp_q0.size() : exp_q1.size();
	endfunction

	task automatic compare_beat(input int lane, input logic [`STRIDE_DATA_W-1:0] actual);
		logic [`STRIDE_DATA_W-1:0] expected;
		if (leftover(lane) == 0) begin
			$display("Test %s: unexpected beat on lane %0d, data %h", test_name, lane, actual);
			errors++;
		end else begin
			expected = (lane == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
			if (actual !== expected) begin
				$display("Fail %s lane %0d: expected %h, actual %h",
					test_name, lane, expected, actual);
				errors++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Falling edge sampling of settled outputs
	////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (!reset) begin
			for (int l = 0; l < 2; l++) begin
				if (lane_beat[l].valid) begin
					compare_beat(l, lane_beat[l].data);
					outstanding[l]++;
				end
				if (lane_credit[l]) begin
					outstanding[l]--;										// Lane consumed a word
				end
				if (outstanding[l] > `STRIDE_CREDITS) begin
					$display("Test %s: lane %0d holds %0d beats without credit",
						test_name, l, outstanding[l]);
					errors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/clock_gen.sv
// Clock and reset source for the strided access testbench
// 8 ns clock, reset held high for the first 5 rising edges
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic	clock,
	output logic	reset
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;											// 8 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;													// Released off the edge
	end

endmodule

`default_nettype wire

//--- hw/strided_access_top.sv
// Strided access unit of one vector cluster
// Two load lanes and a store port share the local memory through the arbiter
// Flow control is credit based toward the lanes and toward the store source
`timescale 1ns/1ps
`default_nettype none

module strided_access_top (
	input  wire logic							clock,
	input  wire logic							reset,
	input  wire logic [2:0]						req_valid,					// Lane 0, lane 1, store
	input  wire access_pkg::desc_t [2:0]		req_desc,					// Descriptor per port
	input  wire logic [1:0]						lane_credit,				// Credit per lane
	input  wire mem_pkg::store_beat_t			store_in,					// Store data beats
	output mem_pkg::load_beat_t [1:0]			lane_beat,					// Load data per lane
	output logic								store_credit,				// Store credit return
	output logic [2:0]							done						// End pulse per port
);

	access_pkg::grant_t		grant;											// Arbiter to generator
	access_pkg::port_id_t	load_port;										// Lane of read data
	mem_pkg::mem_cmd_t		mem_cmd;										// Generator to memory
	mem_pkg::load_beat_t	rd_data;										// Memory read data
	logic					access_end;										// Generator end pulse

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	access_arbiter access_arbiter_inst (
		.clock			(clock),
		.reset			(reset),
		.req_valid		(req_valid),
		.req_desc		(req_desc),
		.access_end		(access_end),
		.grant			(grant)
	);

	stride_addr_gen stride_addr_gen_inst (
		.clock			(clock),
		.reset			(reset),
		.grant			(grant),
		.lane_credit	(lane_credit),
		.store_in		(store_in),
		.mem_cmd		(mem_cmd),
		.load_port		(load_port),
		.store_credit	(store_credit),
		.access_end		(access_end)
	);

	local_memory local_memory_inst (
		.clock			(clock),
		.reset			(reset),
		.mem_cmd		(mem_cmd),
		.rd_data		(rd_data)
	);

	////////////////////////////////////////////////////////////
	// Lane steering and done decode
	////////////////////////////////////////////////////////////

	always_comb begin
		lane_beat[0].valid = rd_data.valid & (load_port == access_pkg::PORT_LANE0);
		lane_beat[0].data = rd_data.data;
		lane_beat[1].valid = rd_data.valid & (load_port == access_pkg::PORT_LANE1);
		lane_beat[1].data = rd_data.data;
		// Grant still holds the ending port
		done = access_end ? (3'b001 << grant.port) : 3'b000;
	end

endmodule

`default_nettype wire

//--- hw/local_memory.sv
// Local data memory of the cluster
// Single port, one access per cycle, read data one cycle after the command
`timescale 1ns/1ps
`include "stride_defs.svh"
`default_nettype none

module local_memory (
	input  wire logic							clock,
	input  wire logic							reset,
	input  wire mem_pkg::mem_cmd_t				mem_cmd,					// Read or write
	output mem_pkg::load_beat_t					rd_data						// Registered read
);

	logic [`STRIDE_DATA_W-1:0]	mem [`STRIDE_MEM_DEPTH];					// Word array
	logic [`STRIDE_DATA_W-1:0]	rd_word;									// Read data register
	logic						rd_valid;									// Read data present
	logic						rd_fire;
	logic						wr_fire;

	always_comb begin
		rd_fire = mem_cmd.valid & ~mem_cmd.write;
		wr_fire = mem_cmd.valid & mem_cmd.write;
	end

	////////////////////////////////////////////////////////////
	// Array and read port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (wr_fire) begin
			mem[mem_cmd.addr] <= mem_cmd.wdata;
		end
		if (rd_fire) begin
			rd_word <= mem[mem_cmd.addr];									// One cycle latency
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_fire;
		end
	end

	always_comb begin
		rd_data.valid = rd_valid;
		rd_data.data = rd_word;
	end

endmodule

`default_nettype wire

//--- hw/stride_addr_gen.sv
// Strided address generator
// Walks base + i * stride for the granted descriptor, loads under lane credit
// and stores one incoming beat per address, then pulses access_end once
`timescale 1ns/1ps
`include "stride_defs.svh"
`default_nettype none

module stride_addr_gen (
	input  wire logic							clock,
	input  wire logic							reset,
	input  wire access_pkg::grant_t				grant,						// From arbiter
	input  wire logic [1:0]						lane_credit,				// Credit return per lane
	input  wire mem_pkg::store_beat_t			store_in,					// Store data
	output mem_pkg::mem_cmd_t					mem_cmd,					// To memory
	output access_pkg::port_id_t				load_port,					// Lane of last read
	output logic								store_credit,				// Beat accepted
	output logic								access_end					// Access finished
);

	localparam int CRED_W = $clog2(`STRIDE_CREDITS + 1);

	logic						busy;										// Descriptor loaded
	logic						end_q;										// Registered end pulse
	logic [`STRIDE_ADDR_W-1:0]	cur_addr;									// Next address
	logic [`STRIDE_ADDR_W-1:0]	remaining;									// Elements left
	logic [CRED_W-1:0]			credit [2];									// Lane credit counters
	logic [1:0]					lane_hit;									// Granted lane, one hot
	logic [1:0]					credit_ok;									// Lane has credit
	logic [1:0]					credit_take;								// Credit spent this cycle
	logic						start;
	logic						has_work;
	logic						load_fire;
	logic						store_fire;
	logic						issue;
	logic [`STRIDE_ADDR_W-1:0]	next_addr;									// Wrapped address

	////////////////////////////////////////////////////////////
	// Issue decision
	////////////////////////////////////////////////////////////

	always_comb begin
		lane_hit[0] = (grant.port == access_pkg::PORT_LANE0);
		lane_hit[1] = (grant.port == access_pkg::PORT_LANE1);
		credit_ok[0] = (credit[0] != '0);
		credit_ok[1] = (credit[1] != '0);
		start = grant.valid & ~busy;										// First cycle of a grant
		has_work = grant.valid & busy & (remaining != '0);
		load_fire = has_work & |(lane_hit & credit_ok);
		store_fire = has_work & (grant.port == access_pkg::PORT_STORE) & store_in.valid;
		issue = load_fire | store_fire;
		credit_take = load_fire ? lane_hit : 2'b00;
		// Depth equals the address range so the carry drops out
		next_addr = cur_addr + grant.desc.stride;
	end

	always_comb begin
		mem_cmd.valid = issue;
		mem_cmd.write = store_fire;
		mem_cmd.addr = cur_addr;
		mem_cmd.wdata = store_in.data;										// Ignored on reads
	end

	////////////////////////////////////////////////////////////
	// Walk state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			end_q <= 1'b0;
			cur_addr <= '0;
			remaining <= '0;
			load_port <= access_pkg::PORT_LANE0;
		end else begin
			// Zero length ends right after loading
			end_q <= (start & (grant.desc.length == '0)) | (issue & (remaining == 'd1));
			if (!grant.valid) begin
				busy <= 1'b0;												// Rearm once grant drops
			end else if (start) begin
				busy <= 1'b1;
			end
			if (start) begin
				cur_addr <= grant.desc.base;
				remaining <= grant.desc.length;
			end else if (issue) begin
				cur_addr <= next_addr;
				remaining <= remaining - 1'b1;
			end
			if (load_fire) begin
				load_port <= grant.port;									// Travels with read data
			end
		end
	end

	// Up on returned credit and down on issue
	always_ff @(posedge clock) begin
		if (reset) begin
			credit[0] <= CRED_W'(`STRIDE_CREDITS);
			credit[1] <= CRED_W'(`STRIDE_CREDITS);
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (credit_take[i] & ~lane_credit[i]) begin
					credit[i] <= credit[i] - 1'b1;
				end else if (lane_credit[i] & ~credit_take[i]) begin
					credit[i] <= credit[i] + 1'b1;
				end
			end
		end
	end

	assign store_credit = store_fire;										// Same cycle as write
	assign access_end = end_q;

endmodule

`default_nettype wire

//--- hw/access_arbiter.sv
// Fixed priority arbiter for the three descriptor requesters
// Lane 0 wins over lane 1, lane 1 over the store port
// A grant is held until the address generator reports the end of the access
`timescale 1ns/1ps
`default_nettype none

module access_arbiter (
	input  wire logic							clock,
	input  wire logic							reset,
	input  wire logic [2:0]						req_valid,					// Request per port
	input  wire access_pkg::desc_t [2:0]		req_desc,					// Descriptor per port
	input  wire logic							access_end,					// Last element done
	output access_pkg::grant_t					grant						// Held grant
);

	access_pkg::grant_t		grant_q;										// Registered grant
	logic [2:0]				skip_mask;										// Port that just ended
	logic [2:0]				masked_req;										// Eligible requests
	logic					pick_valid;										// Someone to grant
	access_pkg::port_id_t	pick_id;										// Winning port

	////////////////////////////////////////////////////////////
	// Priority pick
	////////////////////////////////////////////////////////////

	always_comb begin
		masked_req = req_valid & ~skip_mask;								// Ended port still high
		pick_valid = |masked_req;
		pick_id = access_pkg::PORT_LANE0;
		if (masked_req[0]) begin
			pick_id = access_pkg::PORT_LANE0;								// Highest priority
		end else if (masked_req[1]) begin
			pick_id = access_pkg::PORT_LANE1;
		end else if (masked_req[2]) begin
			pick_id = access_pkg::PORT_STORE;								// Lowest priority
		end
	end

	////////////////////////////////////////////////////////////
	// Grant register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			grant_q <= '0;
			skip_mask <= '0;
		end else begin
			// Mask only for the idle cycle after an end
			skip_mask <= access_end ? (3'b001 << grant_q.port) : 3'b000;
			if (grant_q.valid) begin
				if (access_end) begin
					grant_q.valid <= 1'b0;									// Free next cycle
				end
			end else if (pick_valid) begin
				grant_q.valid <= 1'b1;
				grant_q.port <= pick_id;
				grant_q.desc <= req_desc[pick_id];							// Latch descriptor
			end
		end
	end

	assign grant = grant_q;

endmodule

`default_nettype wire

//--- hw/mem_pkg.sv
// Memory-side types of the strided access unit
// Command into the local memory and the data beats on lanes and store port
`include "stride_defs.svh"
`default_nettype none

package mem_pkg;

	// One memory access with write data ignored on reads
	typedef struct packed {
		logic						valid;								// Command present
		logic						write;								// Store when set
		logic [`STRIDE_ADDR_W-1:0]	addr;								// Word address
		logic [`STRIDE_DATA_W-1:0]	wdata;								// Store data
	} mem_cmd_t;

	typedef struct packed {
		logic						valid;								// Word present
		logic [`STRIDE_DATA_W-1:0]	data;								// Read word
	} load_beat_t;

	typedef struct packed {
		logic						valid;								// Beat present
		logic [`STRIDE_DATA_W-1:0]	data;								// Word to store
	} store_beat_t;

endpackage

`default_nettype wire

//--- hw/access_pkg.sv
// Access-side types of the strided access unit
// Descriptors from the requesters and the grant the arbiter hands on
`include "stride_defs.svh"
`default_nettype none

package access_pkg;

	////////////////////////////////////////////////////////////
	// Requester numbering
	////////////////////////////////////////////////////////////

	typedef logic [1:0] port_id_t;										// Requester number

	localparam port_id_t PORT_LANE0 = 2'd0;								// Load lane 0
	localparam port_id_t PORT_LANE1 = 2'd1;								// Load lane 1
	localparam port_id_t PORT_STORE = 2'd2;								// Store port

	////////////////////////////////////////////////////////////
	// Descriptor and grant
	////////////////////////////////////////////////////////////

	// One strided access where length 0 moves nothing
	typedef struct packed {
		logic [`STRIDE_ADDR_W-1:0]	base;								// First address
		logic [`STRIDE_ADDR_W-1:0]	stride;								// Step per element
		logic [`STRIDE_ADDR_W-1:0]	length;								// Element count
	} desc_t;

	typedef struct packed {
		logic						valid;								// Grant held
		port_id_t					port;								// Granted requester
		desc_t						desc;								// Latched descriptor
	} grant_t;

endpackage

`default_nettype wire

//--- hw/stride_defs.svh
// Sizing macros for the strided access unit
// Included by the packages and by modules that size arrays or counters
`ifndef STRIDE_DEFS_SVH
`define STRIDE_DEFS_SVH

`default_nettype none

// Width of an address, a stride and a length
`define STRIDE_ADDR_W 8

// Width of one data word
`define STRIDE_DATA_W 32

// Words in the local memory and modulus of the address wrap
`define STRIDE_MEM_DEPTH 256

// Starting credit count per load lane and for the store source
`define STRIDE_CREDITS 4

`default_nettype wire

`endif
